// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    // address layout  { tag | index | offset }
    localparam int addr_bits   = 32;
    localparam int tag_bits    = 23;
    localparam int index_bits  = 6;
    localparam int offset_bits = 3;

    // cache geometry
    localparam int num_lines = 64;          // direct mapped, one line per index
    localparam int line_bits = 64;          // 8 bytes per line

    // memory transaction tags, tag 0 means no transaction
    localparam int mem_tag_bits = 4;
    localparam int num_mem_tags = 16;

    // bus command, shared by the processor and memory sides
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_cmd_t;

    // access size of a load or store
    typedef enum logic [1:0] {
        size_byte   = 2'h0,
        size_half   = 2'h1,
        size_word   = 2'h2,
        size_double = 2'h3
    } mem_size_t;

endpackage

// ==== src/store_merge.sv ====
`timescale 1ns/1ps

module store_merge
    import dcache_pkg::*;
(
    input  logic [line_bits-1:0]   line_in,
    input  logic [offset_bits-1:0] offset,
    input  mem_size_t              size,
    input  logic [line_bits-1:0]   store_data,
    output logic [line_bits-1:0]   line_out
);

    always_comb begin
        line_out = line_in;                 // untouched bytes pass through
        case (size)
            size_byte: line_out[{offset, 3'b000} +: 8] = store_data[7:0];
            size_half: line_out[{offset[2:1], 4'b0000} +: 16] = store_data[15:0];
            size_word: line_out[{offset[2], 5'b00000} +: 32] = store_data[31:0];
            default:   line_out = store_data;   // double covers the whole line
        endcase
    end

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_req,
    input  logic [addr_bits-1:0]    wb_addr,
    input  logic [line_bits-1:0]    wb_data,
    output logic                    wb_accept,
    input  logic                    ld_req,
    input  logic [addr_bits-1:0]    ld_addr,
    output logic                    ld_accept,
    output bus_cmd_t                mem_command,
    output logic [addr_bits-1:0]    mem_addr,
    output logic [line_bits-1:0]    mem_data,
    input  logic [mem_tag_bits-1:0] mem_response
);

    logic lock_valid;                       // a rejected request still owns the bus
    logic lock_wb;                          // owner of the lock, 1 = write-back
    logic sel_wb;
    logic sel_ld;
    logic accepted;

    assign accepted = mem_response != '0;

    always_comb begin
        sel_wb = 1'b0;
        sel_ld = 1'b0;
        if (lock_valid && lock_wb && wb_req) begin
            sel_wb = 1'b1;
        end else if (lock_valid && !lock_wb && ld_req) begin
            sel_ld = 1'b1;
        end else if (wb_req) begin
            sel_wb = 1'b1;                  // write-back first on a fresh choice
        end else if (ld_req) begin
            sel_ld = 1'b1;
        end
    end

    assign wb_accept   = sel_wb && accepted;
    assign ld_accept   = sel_ld && accepted;
    assign mem_command = sel_wb ? bus_store : (sel_ld ? bus_load : bus_none);
    assign mem_addr    = sel_wb ? wb_addr : ld_addr;
    assign mem_data    = sel_wb ? wb_data : '0;  // loads carry no data

    // hold the grant across rejections so the bus stays stable
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lock_valid <= 1'b0;
            lock_wb    <= 1'b0;
        end else begin
            lock_valid <= (sel_wb || sel_ld) && !accepted;
            lock_wb    <= sel_wb;
        end
    end

endmodule

// ==== dcache/line_store.sv ====
`timescale 1ns/1ps

module line_store
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [addr_bits-1:0]  lookup_addr,
    output logic                  lookup_hit,
    output logic [line_bits-1:0]  lookup_data,
    output logic                  victim_dirty,
    output logic [tag_bits-1:0]   victim_tag,
    input  logic                  write_en,
    input  logic [index_bits-1:0] write_index,
    input  logic [tag_bits-1:0]   write_tag,
    input  logic [line_bits-1:0]  write_data,
    input  logic                  write_dirty,
    input  logic                  clean_en,
    input  logic [index_bits-1:0] clean_index,
    input  logic [index_bits-1:0] scan_index,
    output logic                  scan_dirty,
    output logic [tag_bits-1:0]   scan_tag,
    output logic [line_bits-1:0]  scan_data
);

    logic [line_bits-1:0]  data_q [num_lines];
    logic [tag_bits-1:0]   tag_q [num_lines];
    logic [num_lines-1:0]  valid_q;
    logic [num_lines-1:0]  dirty_q;
    logic [index_bits-1:0] lookup_index;
    logic [tag_bits-1:0]   lookup_tag;

    assign lookup_index = lookup_addr[offset_bits +: index_bits];
    assign lookup_tag   = lookup_addr[addr_bits-1 -: tag_bits];

    // hit lookup and the line that a miss would replace
    assign lookup_hit   = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign lookup_data  = data_q[lookup_index];
    assign victim_tag   = tag_q[lookup_index];
    assign victim_dirty = valid_q[lookup_index] && dirty_q[lookup_index] && !lookup_hit;

    // flush scan port
    assign scan_dirty = valid_q[scan_index] && dirty_q[scan_index];
    assign scan_tag   = tag_q[scan_index];
    assign scan_data  = data_q[scan_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (clean_en)
                dirty_q[clean_index] <= 1'b0;   // write-back accepted
            if (write_en) begin               // a write after the clean wins
                valid_q[write_index] <= 1'b1;
                dirty_q[write_index] <= write_dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            data_q[write_index] <= write_data;
            tag_q[write_index]  <= write_tag;
        end
    end

endmodule

// ==== dcache/miss_table.sv ====
`timescale 1ns/1ps

module miss_table
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    alloc_en,
    input  logic [mem_tag_bits-1:0] alloc_tag,
    input  logic [addr_bits-1:0]    alloc_addr,
    input  mem_size_t               alloc_size,
    input  logic [line_bits-1:0]    alloc_data,
    input  logic                    alloc_store,
    input  logic [addr_bits-1:0]    probe_addr,
    output logic                    in_flight,
    output logic                    index_busy,
    output logic                    any_pending,
    input  logic [mem_tag_bits-1:0] ret_tag,
    output logic                    ret_valid,
    output logic [addr_bits-1:0]    ret_addr,
    output mem_size_t               ret_size,
    output logic [line_bits-1:0]    ret_data,
    output logic                    ret_store
);

    logic [num_mem_tags-1:0] valid_q;       // entry 0 never allocated
    logic [addr_bits-1:0]    addr_q [num_mem_tags];
    mem_size_t               size_q [num_mem_tags];
    logic [line_bits-1:0]    data_q [num_mem_tags];   // store data, unused for loads
    logic [num_mem_tags-1:0] store_q;

    // same line already requested, or same index with a fill on its way
    always_comb begin
        in_flight  = 1'b0;
        index_busy = 1'b0;
        for (int i = 0; i < num_mem_tags; i++) begin
            if (valid_q[i] &&
                addr_q[i][addr_bits-1:offset_bits] == probe_addr[addr_bits-1:offset_bits])
                in_flight = 1'b1;
            if (valid_q[i] &&
                addr_q[i][offset_bits +: index_bits] == probe_addr[offset_bits +: index_bits])
                index_busy = 1'b1;
        end
    end

    assign any_pending = |valid_q;

    // fill descriptor for the returning tag
    assign ret_valid = (ret_tag != '0) && valid_q[ret_tag];
    assign ret_addr  = addr_q[ret_tag];
    assign ret_size  = size_q[ret_tag];
    assign ret_data  = data_q[ret_tag];
    assign ret_store = store_q[ret_tag];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (ret_valid)
                valid_q[ret_tag] <= 1'b0;
            if (alloc_en)
                valid_q[alloc_tag] <= 1'b1;   // tag reused at once still ends up valid
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            addr_q[alloc_tag]  <= alloc_addr;
            size_q[alloc_tag]  <= alloc_size;
            data_q[alloc_tag]  <= alloc_data;
            store_q[alloc_tag] <= alloc_store;
        end
    end

endmodule

// ==== dcache/evict_unit.sv ====
`timescale 1ns/1ps

module evict_unit
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  halt,
    input  logic                  conflict_dirty,
    input  logic [addr_bits-1:0]  conflict_addr,
    input  logic [line_bits-1:0]  conflict_data,
    input  logic                  scan_dirty,
    input  logic [tag_bits-1:0]   scan_tag,
    input  logic [line_bits-1:0]  scan_data,
    output logic [index_bits-1:0] scan_index,
    output logic                  wb_req,
    output logic [addr_bits-1:0]  wb_addr,
    output logic [line_bits-1:0]  wb_data,
    input  logic                  wb_accept,
    output logic                  clean_en,
    output logic [index_bits-1:0] clean_index,
    output logic                  flush_done
);

    logic pass_clean;                       // no dirty line seen in this scan pass

    assign clean_en    = wb_req && wb_accept;
    assign clean_index = wb_addr[offset_bits +: index_bits];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_req     <= 1'b0;
            scan_index <= '0;
            pass_clean <= 1'b1;
            flush_done <= 1'b0;
        end else if (wb_req) begin
            if (wb_accept)
                wb_req <= 1'b0;
        end else if (halt) begin
            if (!flush_done) begin
                if (scan_dirty) begin
                    wb_req     <= 1'b1;     // pointer stays, rechecked once clean
                    pass_clean <= 1'b0;
                end else begin
                    scan_index <= scan_index + 1'b1;
                    if (scan_index == index_bits'(num_lines - 1)) begin
                        flush_done <= pass_clean;   // done after a pass with nothing dirty
                        pass_clean <= 1'b1;
                    end
                end
            end
        end else begin
            flush_done <= 1'b0;
            pass_clean <= 1'b1;
            scan_index <= '0;
            if (conflict_dirty)
                wb_req <= 1'b1;             // victim captured this cycle
        end
    end

    // victim capture, frozen while the write-back waits
    always_ff @(posedge clk) begin
        if (!wb_req) begin
            if (halt) begin
                wb_addr <= {scan_tag, scan_index, {offset_bits{1'b0}}};
                wb_data <= scan_data;
            end else begin
                wb_addr <= conflict_addr;
                wb_data <= conflict_data;
            end
        end
    end

endmodule

// ==== dcache/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  bus_cmd_t                proc_command,
    input  logic [addr_bits-1:0]    proc_addr,
    input  mem_size_t               proc_size,
    input  logic [line_bits-1:0]    proc_data,
    input  logic                    halt,
    output logic                    hit,
    output logic [line_bits-1:0]    hit_data,
    output logic [mem_tag_bits-1:0] data_response,
    output logic [mem_tag_bits-1:0] data_tag,
    output logic                    halt_confirm,
    output bus_cmd_t                mem_command,
    output logic [addr_bits-1:0]    mem_addr,
    output logic [line_bits-1:0]    mem_data,
    input  logic [mem_tag_bits-1:0] mem_response,
    input  logic [line_bits-1:0]    mem_rdata,
    input  logic [mem_tag_bits-1:0] mem_tag
);

    logic [index_bits-1:0] proc_index;
    logic [tag_bits-1:0]   proc_tag;
    logic                  req_valid;
    logic                  is_store;
    logic                  lookup_hit;
    logic [line_bits-1:0]  lookup_data;
    logic                  victim_dirty;
    logic [tag_bits-1:0]   victim_tag;
    logic                  in_flight;
    logic                  index_busy;
    logic                  any_pending;
    logic                  ret_valid;
    logic [addr_bits-1:0]  ret_addr;
    mem_size_t             ret_size;
    logic [line_bits-1:0]  ret_data;
    logic                  ret_store;
    logic                  hit_valid;
    logic                  store_hit;
    logic [line_bits-1:0]  hit_line;
    logic [line_bits-1:0]  fill_line;
    logic                  write_en;
    logic [index_bits-1:0] write_index;
    logic [tag_bits-1:0]   write_tag;
    logic [line_bits-1:0]  write_data;
    logic                  write_dirty;
    logic                  conflict;
    logic [addr_bits-1:0]  conflict_addr;
    logic                  miss_req;
    logic [addr_bits-1:0]  miss_addr;
    logic                  ld_accept;
    logic                  flush_go;
    logic                  wb_req;
    logic [addr_bits-1:0]  wb_addr;
    logic [line_bits-1:0]  wb_data;
    logic                  wb_accept;
    logic                  clean_en;
    logic [index_bits-1:0] clean_index;
    logic [index_bits-1:0] scan_index;
    logic                  scan_dirty;
    logic [tag_bits-1:0]   scan_tag;
    logic [line_bits-1:0]  scan_data;
    logic                  flush_done;

    assign proc_index = proc_addr[offset_bits +: index_bits];
    assign proc_tag   = proc_addr[addr_bits-1 -: tag_bits];
    assign req_valid  = proc_command != bus_none;
    assign is_store   = proc_command == bus_store;

    // a fill owns the arrays this cycle, and stores wait out a pending fill or halt
    assign hit_valid = req_valid && lookup_hit && !ret_valid &&
                       !(is_store && (index_busy || halt));
    assign store_hit = hit_valid && is_store;

    // dirty victim in the way, evict first
    assign conflict      = req_valid && !lookup_hit && victim_dirty && !halt;
    assign conflict_addr = {victim_tag, proc_index, {offset_bits{1'b0}}};

    assign miss_req  = req_valid && !lookup_hit && !victim_dirty && !in_flight &&
                       !index_busy && !wb_req && !halt;
    assign miss_addr = {proc_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
    assign flush_go  = halt && !any_pending;  // scan once outstanding fills drain

    // single write port, fills before store hits
    assign write_en = ret_valid || store_hit;
    always_comb begin
        if (ret_valid) begin
            write_index = ret_addr[offset_bits +: index_bits];
            write_tag   = ret_addr[addr_bits-1 -: tag_bits];
            write_data  = ret_store ? fill_line : mem_rdata;
            write_dirty = ret_store;        // store miss lands dirty
        end else begin
            write_index = proc_index;
            write_tag   = proc_tag;
            write_data  = hit_line;
            write_dirty = 1'b1;
        end
    end

    line_store u_line_store (
        .clk, .reset,
        .lookup_addr(proc_addr), .lookup_hit, .lookup_data,
        .victim_dirty, .victim_tag,
        .write_en, .write_index, .write_tag, .write_data, .write_dirty,
        .clean_en, .clean_index,
        .scan_index, .scan_dirty, .scan_tag, .scan_data
    );

    miss_table u_miss_table (
        .clk, .reset,
        .alloc_en(ld_accept), .alloc_tag(mem_response), .alloc_addr(proc_addr),
        .alloc_size(proc_size), .alloc_data(proc_data), .alloc_store(is_store),
        .probe_addr(proc_addr), .in_flight, .index_busy, .any_pending,
        .ret_tag(mem_tag), .ret_valid, .ret_addr, .ret_size, .ret_data, .ret_store
    );

    evict_unit u_evict_unit (
        .clk, .reset, .halt(flush_go),
        .conflict_dirty(conflict), .conflict_addr, .conflict_data(lookup_data),
        .scan_dirty, .scan_tag, .scan_data, .scan_index,
        .wb_req, .wb_addr, .wb_data, .wb_accept,
        .clean_en, .clean_index, .flush_done
    );

    mem_arbiter u_mem_arbiter (
        .clk, .reset,
        .wb_req, .wb_addr, .wb_data, .wb_accept,
        .ld_req(miss_req), .ld_addr(miss_addr), .ld_accept,
        .mem_command, .mem_addr, .mem_data, .mem_response
    );

    store_merge u_hit_merge (
        .line_in(lookup_data), .offset(proc_addr[offset_bits-1:0]), .size(proc_size),
        .store_data(proc_data), .line_out(hit_line)
    );

    store_merge u_fill_merge (
        .line_in(mem_rdata), .offset(ret_addr[offset_bits-1:0]), .size(ret_size),
        .store_data(ret_data), .line_out(fill_line)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit           <= 1'b0;
            data_response <= '0;
            data_tag      <= '0;
            halt_confirm  <= 1'b0;
        end else begin
            hit           <= hit_valid;
            data_response <= ld_accept ? mem_response : '0;   // tag the processor waits on
            data_tag      <= (ret_valid && !ret_store) ? mem_tag : '0;
            halt_confirm  <= halt && flush_done && !any_pending;
        end
    end

    // load data, a returning load fill takes the slot
    always_ff @(posedge clk) begin
        hit_data <= (ret_valid && !ret_store) ? mem_rdata : lookup_data;
    end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  bus_cmd_t                mem_command,
    input  logic [addr_bits-1:0]    mem_addr,
    input  logic [line_bits-1:0]    mem_data,
    output logic [mem_tag_bits-1:0] mem_response,
    output logic [line_bits-1:0]    mem_rdata,
    output logic [mem_tag_bits-1:0] mem_tag
);

    localparam int latency = 4;             // accept to return, in cycles

    logic [line_bits-1:0]    store_q [256]; // 256 doublewords, addr[10:3]
    logic [7:0]              line_q [num_mem_tags];
    logic [2:0]              count_q [num_mem_tags];  // cycles left, 0 = tag free
    logic [31:0]             rng_q;
    logic [mem_tag_bits-1:0] free_tag;
    logic                    reject;

    // lowest free tag, tag 0 stays reserved
    always_comb begin
        free_tag = '0;
        for (int t = num_mem_tags - 1; t >= 1; t--)
            if (count_q[t] == 3'd0)
                free_tag = mem_tag_bits'(t);
    end

    assign reject       = rng_q[31:30] == 2'b00;   // about one request in four
    assign mem_response = (mem_command != bus_none && !reject) ? free_tag : '0;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            rng_q     <= 32'd46265;
            mem_tag   <= '0;
            mem_rdata <= '0;
            for (int t = 0; t < num_mem_tags; t++)
                count_q[t] <= 3'd0;
            for (int i = 0; i < 256; i++)
                store_q[i] <= 64'h9e3779b97f4a7c15 * 64'(i + 1);  // differs on every address bit
        end else begin
            rng_q   <= rng_q * 32'd1664525 + 32'd1013904223;
            mem_tag <= '0;
            for (int t = 1; t < num_mem_tags; t++) begin
                if (count_q[t] == 3'd1) begin
                    mem_tag   <= mem_tag_bits'(t);     // one return per cycle at most
                    mem_rdata <= store_q[line_q[t]];
                end
                if (count_q[t] != 3'd0)
                    count_q[t] <= count_q[t] - 3'd1;
            end
            if (mem_command == bus_load && mem_response != '0) begin
                count_q[mem_response] <= 3'(latency);
                line_q[mem_response]  <= mem_addr[10:3];
            end
            if (mem_command == bus_store && mem_response != '0)
                store_q[mem_addr[10:3]] <= mem_data;   // write-back lands at accept
        end
    end

endmodule

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int num_directed = 12;
    localparam int num_random   = 40;
    // about 50 cycles per access with rejections and write-backs, plus the flush pass
    localparam int max_cycles   = (num_directed + num_random) * 50 + 1400;

    logic clk = 1'b0;
    logic reset;
    bus_cmd_t proc_command;
    logic [31:0] proc_addr;
    mem_size_t proc_size;
    logic [63:0] proc_data;
    logic halt;
    logic hit;
    logic [63:0] hit_data;
    logic [3:0] data_response;
    logic [3:0] data_tag;
    logic halt_confirm;
    bus_cmd_t mem_command;
    logic [31:0] mem_addr;
    logic [63:0] mem_data;
    logic [3:0] mem_response;
    logic [63:0] mem_rdata;
    logic [3:0] mem_tag;

    logic [7:0] ref_bytes [2048];          // reference memory, byte addressed
    logic [255:0] touched;
    logic [31:0] tag_addr [16];            // request address per memory tag
    logic [3:0] wait_tag;                  // tag of the load being waited on
    logic ended_hit;                       // last access finished with a hit
    logic [31:0] seed = 32'd46265;
    int value_errors = 0;
    int protocol_errors = 0;
    int cycles = 0;
    bus_cmd_t last_cmd;                    // request seen at the last edge
    logic [63:0] last_line;
    logic [63:0] exp_fill;
    logic expect_wb = 1'b0;
    logic wb_seen;
    bus_cmd_t prev_cmd;
    logic [31:0] prev_addr;
    logic [63:0] prev_data;
    logic prev_rejected;

    always #50 clk = ~clk;

    dcache_top u_dcache_top (
        .clk, .reset, .proc_command, .proc_addr, .proc_size, .proc_data, .halt,
        .hit, .hit_data, .data_response, .data_tag, .halt_confirm,
        .mem_command, .mem_addr, .mem_data, .mem_response, .mem_rdata, .mem_tag
    );

    mem_model u_mem (
        .clk, .reset, .mem_command, .mem_addr, .mem_data,
        .mem_response, .mem_rdata, .mem_tag
    );

    function automatic logic [63:0] ref_line(input logic [31:0] addr);
        logic [63:0] line;
        for (int k = 0; k < 8; k++)
            line[8*k +: 8] = ref_bytes[{addr[10:3], 3'(k)}];   // little endian
        return line;
    endfunction

    function automatic logic [15:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];                // high bits, low ones cycle too fast
    endfunction

    task automatic apply_store(input logic [31:0] addr, input mem_size_t size,
                               input logic [63:0] data);
        for (int k = 0; k < (1 << int'(size)); k++)
            ref_bytes[11'(addr[10:0] + 11'(k))] = data[8*k +: 8];
    endtask

    // hold the request until hit or accept, then wait out a load fill
    task automatic access(input bus_cmd_t cmd, input logic [31:0] addr,
                          input mem_size_t size, input logic [63:0] data);
        proc_command = cmd;
        proc_addr = addr;
        proc_size = size;
        proc_data = data;
        touched[addr[10:3]] = 1'b1;
        if (cmd == bus_store)
            apply_store(addr, size, data);     // program order
        @(posedge clk);
        #1;
        while (!hit && data_response == '0) begin
            @(posedge clk);
            #1;
        end
        proc_command = bus_none;
        ended_hit = hit;
        if (!hit) begin
            tag_addr[data_response] = addr;
            if (cmd == bus_load) begin
                wait_tag = data_response;
                while (data_tag != wait_tag) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    task automatic print_counts();
        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
    endtask

    // expected values lined up with the registered outputs
    always @(posedge clk) begin
        last_cmd <= proc_command;
        last_line <= ref_line(proc_addr);
        exp_fill <= ref_line(tag_addr[mem_tag]);
        prev_cmd <= mem_command;
        prev_addr <= mem_addr;
        prev_data <= mem_data;
        prev_rejected <= mem_command != bus_none && mem_response == '0;
        if (!expect_wb)
            wb_seen <= 1'b0;
        else if (mem_command == bus_store && mem_response != '0)
            wb_seen <= 1'b1;
    end

    assert property (@(posedge clk) disable iff (reset)
        (hit && last_cmd == bus_load) |-> hit_data == last_line)
    else begin
        value_errors++;
        $display("ERROR %0t hit_data expected %h got %h", $time, last_line, hit_data);
    end

    assert property (@(posedge clk) disable iff (reset)
        data_tag != '0 |-> hit_data == exp_fill)
    else begin
        value_errors++;
        $display("ERROR %0t hit_data expected %h got %h on fill", $time, exp_fill, hit_data);
    end

    assert property (@(posedge clk) disable iff (reset)
        data_tag != '0 |-> data_tag == wait_tag)
    else begin
        protocol_errors++;
        $display("ERROR %0t data_tag expected %h got %h", $time, wait_tag, data_tag);
    end

    assert property (@(posedge clk) disable iff (reset)
        prev_rejected |-> (mem_command == prev_cmd && mem_addr == prev_addr &&
                           mem_data == prev_data))
    else begin
        protocol_errors++;
        $display("ERROR %0t mem_command/mem_addr/mem_data expected %0d/%h/%h got %0d/%h/%h",
                 $time, prev_cmd, prev_addr, prev_data, mem_command, mem_addr, mem_data);
    end

    assert property (@(posedge clk) disable iff (reset)
        (expect_wb && mem_command == bus_load && mem_response != '0) |-> wb_seen)
    else begin
        protocol_errors++;
        $display("%0t: miss load went out before the dirty line was written back", $time);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("run stopped after %0d cycles, a request or the flush never finished",
                     cycles);
            print_counts();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin : stimulus
        logic [63:0] init_line;
        logic [15:0] r;
        mem_size_t size;
        logic [2:0] offset;
        logic [31:0] addr;
        logic [63:0] data;
        for (int i = 0; i < 256; i++) begin
            init_line = 64'h9e3779b97f4a7c15 * 64'(i + 1);   // same fill as memory
            for (int k = 0; k < 8; k++)
                ref_bytes[i*8 + k] = init_line[8*k +: 8];
        end
        for (int t = 0; t < 16; t++)
            tag_addr[t] = '0;
        touched = '0;
        wait_tag = '0;
        reset = 1'b1;
        halt = 1'b0;
        proc_command = bus_none;
        proc_addr = '0;
        proc_size = size_byte;
        proc_data = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        access(bus_load, 32'h048, size_double, '0);       // miss, then fill
        access(bus_load, 32'h048, size_double, '0);       // same line hits
        assert (ended_hit)
        else begin
            protocol_errors++;
            $display("%0t: repeated load of a filled line missed instead of hitting", $time);
        end
        access(bus_store, 32'h049, size_byte, 64'ha5);
        access(bus_store, 32'h04a, size_half, 64'hbeef);
        access(bus_store, 32'h04c, size_word, 64'h1234_5678);
        access(bus_load, 32'h048, size_double, '0);
        access(bus_store, 32'h048, size_double, 64'hfeed_face_cafe_f00d);
        access(bus_load, 32'h048, size_double, '0);
        access(bus_store, 32'h0c4, size_word, 64'h0bad_c0de);  // store miss
        access(bus_load, 32'h0c0, size_double, '0);       // waits for the merged fill

        expect_wb = 1'b1;                  // index 9 holds a dirty line
        access(bus_load, 32'h248, size_double, '0);
        expect_wb = 1'b0;
        access(bus_load, 32'h048, size_double, '0);       // old line back from memory

        // small index and tag range so hits and conflicts are common
        repeat (num_random) begin
            r = next_rand();
            size = mem_size_t'(r[6:5]);
            offset = 3'((r[9:7] >> int'(size)) << int'(size));   // aligned to size
            addr = (32'(r[1:0]) << 9) | (32'(r[4:2]) << 3) | 32'(offset);
            data = {next_rand(), next_rand(), next_rand(), next_rand()};
            access(r[10] ? bus_store : bus_load, addr, size, data);
        end

        halt = 1'b1;
        while (!halt_confirm) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < 256; i++) begin
            if (touched[i]) begin
                assert (u_mem.store_q[i] == ref_line(32'(i) << 3))
                else begin
                    value_errors++;
                    $display("ERROR %0t store_q[%0d] expected %h got %h", $time, i,
                             ref_line(32'(i) << 3), u_mem.store_q[i]);
                end
            end
        end

        print_counts();
        if (value_errors + protocol_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== tb.f ====
common/dcache_pkg.sv
src/store_merge.sv
src/mem_arbiter.sv
dcache/line_store.sv
dcache/miss_table.sv
dcache/evict_unit.sv
dcache/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the dcache testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
